//--- source/cpu_pkg.sv
package cpu_pkg;

    localparam int xlen = 32;

    typedef logic [4:0] reg_addr_t;

    // Major opcodes of the supported subset
    localparam logic [6:0] op_op     = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_pass_b
    } alu_op_t;

    // All-zero value is a bubble
    typedef struct packed {
        alu_op_t alu_op;
        logic    use_imm;
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    is_branch;
        logic    branch_ne;
        logic    is_jump;
    } ctrl_t;

    typedef struct packed {
        ctrl_t            ctrl;
        logic [xlen-1:0]  pc;
        logic [xlen-1:0]  rs1_data;
        logic [xlen-1:0]  rs2_data;
        reg_addr_t        rs1;
        reg_addr_t        rs2;
        reg_addr_t        rd;
        logic [xlen-1:0]  imm;
    } id_ex_t;

    typedef struct packed {
        logic             reg_write;
        logic             mem_read;
        logic             mem_write;
        reg_addr_t        rd;
        logic [xlen-1:0]  result;
        logic [xlen-1:0]  store_data;
    } ex_mem_t;

    // ADDI x0, x0, 0
    localparam logic [xlen-1:0] nop_instr = 32'h0000_0013;

endpackage

//--- source/result_if.sv
interface result_if import cpu_pkg::*; ();

    // Instruction currently in MEM
    logic             mem_valid_write;
    reg_addr_t        mem_rd;
    logic [xlen-1:0]  mem_data;

    // Instruction currently in WB
    logic             wb_write;
    reg_addr_t        wb_rd;
    logic [xlen-1:0]  wb_data;

    modport source (
        output mem_valid_write, mem_rd, mem_data,
        output wb_write, wb_rd, wb_data
    );

    modport fwd (
        input mem_valid_write, mem_rd, mem_data,
        input wb_write, wb_rd, wb_data
    );

    modport rf (
        input wb_write, wb_rd, wb_data
    );

endinterface

//--- source/fetch_stage.sv
module fetch_stage import cpu_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             stall,
    input  logic             redirect,
    input  logic [xlen-1:0]  redirect_pc,
    output logic [xlen-1:0]  imem_addr,
    input  logic [xlen-1:0]  imem_data,
    output logic [xlen-1:0]  if_id_pc,
    output logic [xlen-1:0]  if_id_instr
);

    logic [xlen-1:0] pc;
    logic [xlen-1:0] pc_next;

    // Redirect wins, a stall holds the current fetch
    always_comb begin
        if (redirect) begin
            pc_next = redirect_pc;
        end else if (stall) begin
            pc_next = pc;
        end else begin
            pc_next = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    // Instruction memory answers in the same cycle
    assign imem_addr = pc;

    always_ff @(posedge clk) begin
        if (rst || redirect) begin
            if_id_instr <= nop_instr;
        end else if (!stall) begin
            if_id_instr <= imem_data;
        end
        if (!stall) begin
            if_id_pc <= pc;
        end
    end

endmodule

//--- source/decode_stage.sv
module decode_stage import cpu_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic [xlen-1:0]  if_id_pc,
    input  logic [xlen-1:0]  if_id_instr,
    input  logic             redirect,
    result_if.rf             rf,
    output logic             stall,
    output id_ex_t           id_ex
);

    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic             alt_op;
    reg_addr_t        rs1;
    reg_addr_t        rs2;
    reg_addr_t        rd;
    ctrl_t            ctrl;
    logic [xlen-1:0]  imm;
    logic [xlen-1:0]  rs1_data;
    logic [xlen-1:0]  rs2_data;
    logic             uses_rs1;
    logic             uses_rs2;
    logic [xlen-1:0]  regs [1:31];

    assign opcode = if_id_instr[6:0];
    assign rd     = if_id_instr[11:7];
    assign funct3 = if_id_instr[14:12];
    assign rs1    = if_id_instr[19:15];
    assign rs2    = if_id_instr[24:20];
    assign alt_op = if_id_instr[30];

    always_comb begin
        ctrl = '0;
        case (opcode)
            op_op: begin
                ctrl.reg_write = 1'b1;
                case (funct3)
                    3'b000:  ctrl.alu_op = alt_op ? alu_sub : alu_add;
                    3'b001:  ctrl.alu_op = alu_sll;
                    3'b010:  ctrl.alu_op = alu_slt;
                    3'b100:  ctrl.alu_op = alu_xor;
                    3'b101:  ctrl.alu_op = alt_op ? alu_sra : alu_srl;
                    3'b110:  ctrl.alu_op = alu_or;
                    3'b111:  ctrl.alu_op = alu_and;
                    default: ctrl.alu_op = alu_add;
                endcase
            end
            op_imm: begin
                ctrl.reg_write = 1'b1;
                ctrl.use_imm   = 1'b1;
                case (funct3)
                    3'b010:  ctrl.alu_op = alu_slt;
                    3'b100:  ctrl.alu_op = alu_xor;
                    3'b110:  ctrl.alu_op = alu_or;
                    3'b111:  ctrl.alu_op = alu_and;
                    default: ctrl.alu_op = alu_add;
                endcase
            end
            op_lui: begin
                ctrl.reg_write = 1'b1;
                ctrl.use_imm   = 1'b1;
                ctrl.alu_op    = alu_pass_b;
            end
            op_load: begin
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.use_imm   = 1'b1;
            end
            op_store: begin
                ctrl.mem_write = 1'b1;
                ctrl.use_imm   = 1'b1;
            end
            op_branch: begin
                ctrl.is_branch = 1'b1;
                ctrl.branch_ne = funct3[0];
            end
            op_jal: begin
                ctrl.reg_write = 1'b1;
                ctrl.is_jump   = 1'b1;
            end
            // Anything else decodes as a bubble
            default: ctrl = '0;
        endcase
    end

    always_comb begin
        case (opcode)
            op_store:  imm = {{20{if_id_instr[31]}}, if_id_instr[31:25], if_id_instr[11:7]};
            op_branch: imm = {{19{if_id_instr[31]}}, if_id_instr[31], if_id_instr[7],
                              if_id_instr[30:25], if_id_instr[11:8], 1'b0};
            op_lui:    imm = {if_id_instr[31:12], 12'b0};
            op_jal:    imm = {{11{if_id_instr[31]}}, if_id_instr[31], if_id_instr[19:12],
                              if_id_instr[20], if_id_instr[30:21], 1'b0};
            default:   imm = {{20{if_id_instr[31]}}, if_id_instr[31:20]};
        endcase
    end

    always_ff @(posedge clk) begin
        if (rf.wb_write && rf.wb_rd != '0) begin
            regs[rf.wb_rd] <= rf.wb_data;
        end
    end

    // x0 reads zero, WB write is visible in the same cycle
    function automatic logic [xlen-1:0] read_reg(reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end else if (rf.wb_write && rf.wb_rd == addr) begin
            return rf.wb_data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs1_data = read_reg(rs1);
        rs2_data = read_reg(rs2);
    end

    // Load in EX feeding this instruction
    assign uses_rs1 = (opcode != op_lui) && (opcode != op_jal);
    assign uses_rs2 = (opcode == op_op) || (opcode == op_store) || (opcode == op_branch);
    assign stall = id_ex.ctrl.mem_read && (id_ex.rd != '0) &&
                   ((uses_rs1 && id_ex.rd == rs1) || (uses_rs2 && id_ex.rd == rs2));

    always_ff @(posedge clk) begin
        if (rst || stall || redirect) begin
            id_ex.ctrl <= '0;
        end else begin
            id_ex.ctrl <= ctrl;
        end
        id_ex.pc       <= if_id_pc;
        id_ex.rs1_data <= rs1_data;
        id_ex.rs2_data <= rs2_data;
        id_ex.rs1      <= rs1;
        id_ex.rs2      <= rs2;
        id_ex.rd       <= rd;
        id_ex.imm      <= imm;
    end

endmodule

//--- source/execute_stage.sv
module execute_stage import cpu_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  id_ex_t           id_ex,
    result_if.fwd            fwd,
    output logic             redirect,
    output logic [xlen-1:0]  redirect_pc,
    output ex_mem_t          ex_mem
);

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] rs2_val;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] alu_out;
    logic [xlen-1:0] result;
    logic            equal;
    logic            taken;

    // Youngest producer first, x0 is never forwarded
    function automatic logic [xlen-1:0] fwd_operand(reg_addr_t src, logic [xlen-1:0] id_val);
        if (src == '0) begin
            return id_val;
        end else if (fwd.mem_valid_write && fwd.mem_rd == src) begin
            return fwd.mem_data;
        end else if (fwd.wb_write && fwd.wb_rd == src) begin
            return fwd.wb_data;
        end
        return id_val;
    endfunction

    always_comb begin
        op_a    = fwd_operand(id_ex.rs1, id_ex.rs1_data);
        rs2_val = fwd_operand(id_ex.rs2, id_ex.rs2_data);
    end

    assign op_b = id_ex.ctrl.use_imm ? id_ex.imm : rs2_val;

    always_comb begin
        case (id_ex.ctrl.alu_op)
            alu_add:    alu_out = op_a + op_b;
            alu_sub:    alu_out = op_a - op_b;
            alu_and:    alu_out = op_a & op_b;
            alu_or:     alu_out = op_a | op_b;
            alu_xor:    alu_out = op_a ^ op_b;
            alu_slt:    alu_out = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            alu_sll:    alu_out = op_a << op_b[4:0];
            alu_srl:    alu_out = op_a >> op_b[4:0];
            alu_sra:    alu_out = $signed(op_a) >>> op_b[4:0];
            alu_pass_b: alu_out = op_b;
            default:    alu_out = op_a + op_b;
        endcase
    end

    // BEQ and BNE share the comparator
    assign equal = (op_a == rs2_val);
    assign taken = id_ex.ctrl.is_branch && (equal ^ id_ex.ctrl.branch_ne);

    assign redirect    = taken || id_ex.ctrl.is_jump;
    assign redirect_pc = id_ex.pc + id_ex.imm;

    // Link value for JAL
    assign result = id_ex.ctrl.is_jump ? id_ex.pc + 32'd4 : alu_out;

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_mem.reg_write <= 1'b0;
            ex_mem.mem_read  <= 1'b0;
            ex_mem.mem_write <= 1'b0;
        end else begin
            ex_mem.reg_write <= id_ex.ctrl.reg_write;
            ex_mem.mem_read  <= id_ex.ctrl.mem_read;
            ex_mem.mem_write <= id_ex.ctrl.mem_write;
        end
        ex_mem.rd         <= id_ex.rd;
        ex_mem.result     <= result;
        ex_mem.store_data <= rs2_val;
    end

endmodule

//--- source/memory_writeback.sv
module memory_writeback import cpu_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  ex_mem_t          ex_mem,
    output logic [xlen-1:0]  dm_addr,
    output logic [xlen-1:0]  dm_wdata,
    output logic             dm_we,
    input  logic [xlen-1:0]  dm_rdata,
    result_if.source         res
);

    logic             wb_write;
    reg_addr_t        wb_rd;
    logic [xlen-1:0]  wb_data;

    // Data port straight from EX/MEM
    assign dm_addr  = ex_mem.result;
    assign dm_wdata = ex_mem.store_data;
    assign dm_we    = ex_mem.mem_write;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_write <= 1'b0;
        end else begin
            wb_write <= ex_mem.reg_write;
        end
        wb_rd <= ex_mem.rd;
        // Load data arrives combinationally from the memory
        wb_data <= ex_mem.mem_read ? dm_rdata : ex_mem.result;
    end

    // A load in MEM has no value yet, decode stalls for it
    assign res.mem_valid_write = ex_mem.reg_write && !ex_mem.mem_read;
    assign res.mem_rd          = ex_mem.rd;
    assign res.mem_data        = ex_mem.result;

    assign res.wb_write = wb_write;
    assign res.wb_rd    = wb_rd;
    assign res.wb_data  = wb_data;

endmodule

//--- source/cpu.sv
module cpu import cpu_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    output logic [xlen-1:0]  imem_addr,
    input  logic [xlen-1:0]  imem_data,
    output logic [xlen-1:0]  dm_addr,
    output logic             dm_we,
    output logic [xlen-1:0]  dm_wdata,
    input  logic [xlen-1:0]  dm_rdata
);

    logic             stall;
    logic             redirect;
    logic [xlen-1:0]  redirect_pc;
    logic [xlen-1:0]  if_id_pc;
    logic [xlen-1:0]  if_id_instr;
    id_ex_t           id_ex;
    ex_mem_t          ex_mem;

    // MEM and WB results for forwarding and register write
    result_if res ();

    fetch_stage fetch0 (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .imem_addr   (imem_addr),
        .imem_data   (imem_data),
        .if_id_pc    (if_id_pc),
        .if_id_instr (if_id_instr)
    );

    decode_stage decode0 (
        .clk         (clk),
        .rst         (rst),
        .if_id_pc    (if_id_pc),
        .if_id_instr (if_id_instr),
        .redirect    (redirect),
        .rf          (res.rf),
        .stall       (stall),
        .id_ex       (id_ex)
    );

    execute_stage execute0 (
        .clk         (clk),
        .rst         (rst),
        .id_ex       (id_ex),
        .fwd         (res.fwd),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .ex_mem      (ex_mem)
    );

    memory_writeback mem_wb0 (
        .clk      (clk),
        .rst      (rst),
        .ex_mem   (ex_mem),
        .dm_addr  (dm_addr),
        .dm_wdata (dm_wdata),
        .dm_we    (dm_we),
        .dm_rdata (dm_rdata),
        .res      (res.source)
    );

endmodule

//--- sim/cpu_properties.sv
module cpu_properties import cpu_pkg::*; (
    input logic             clk,
    input logic             rst,
    input logic             dm_we,
    input logic [xlen-1:0]  dm_addr,
    input logic [xlen-1:0]  imem_addr
);

    timeunit 1ns;
    timeprecision 100ps;

    // Pipeline registers hold bubbles for two cycles after reset
    quiet_after_reset: assert property (@(posedge clk) (rst || $past(rst)) |=> !dm_we)
        else $error("dm_we asserted within two cycles of reset");

    store_addr_known: assert property (@(posedge clk) disable iff (rst)
        $rose(dm_we) |-> !$isunknown(dm_addr))
        else $error("dm_we rose while dm_addr is unknown");

    fetch_aligned: assert property (@(posedge clk) disable iff (rst)
        imem_addr[1:0] == 2'b00)
        else $error("imem_addr not word aligned: %h", imem_addr);

endmodule

bind cpu cpu_properties props0 (
    .clk       (clk),
    .rst       (rst),
    .dm_we     (dm_we),
    .dm_addr   (dm_addr),
    .imem_addr (imem_addr)
);

//--- sim/tb_cpu.sv
module tb_cpu import cpu_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    logic             clk;
    logic             rst;
    logic [xlen-1:0]  imem_addr;
    logic [xlen-1:0]  imem_data;
    logic [xlen-1:0]  dm_addr;
    logic             dm_we;
    logic [xlen-1:0]  dm_wdata;
    logic [xlen-1:0]  dm_rdata;

    logic [xlen-1:0]  imem [0:255];
    logic [xlen-1:0]  dmem [0:255];
    logic [xlen-1:0]  prog [$];
    logic [xlen-1:0]  exp_addr [$];
    logic [xlen-1:0]  exp_data [$];
    logic [xlen-1:0]  seen_addr [$];
    logic [xlen-1:0]  seen_data [$];
    int               seed;

    cpu dut0 (
        .clk       (clk),
        .rst       (rst),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .dm_addr   (dm_addr),
        .dm_we     (dm_we),
        .dm_wdata  (dm_wdata),
        .dm_rdata  (dm_rdata)
    );

    always #2 clk = ~clk;

    // Both memories answer in the same cycle
    assign imem_data = imem[imem_addr[9:2]];
    assign dm_rdata  = dmem[dm_addr[9:2]];

    always @(posedge clk) begin
        if (dm_we) begin
            dmem[dm_addr[9:2]] = dm_wdata;
            if (!rst) begin
                seen_addr.push_back(dm_addr);
                seen_data.push_back(dm_wdata);
            end
        end
    end

    function automatic logic [xlen-1:0] fill_word(int idx);
        return 32'h5a00_0000 + 32'(idx) * 32'h0001_0101;
    endfunction

    function automatic logic [xlen-1:0] r_type(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                               logic [2:0] f3, reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, op_op};
    endfunction

    function automatic logic [xlen-1:0] i_type(logic [11:0] imm, reg_addr_t rs1,
                                               logic [2:0] f3, reg_addr_t rd);
        return {imm, rs1, f3, rd, op_imm};
    endfunction

    function automatic logic [xlen-1:0] lw_instr(reg_addr_t rd, reg_addr_t rs1, logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, op_load};
    endfunction

    function automatic logic [xlen-1:0] sw_instr(reg_addr_t rs2, reg_addr_t rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op_store};
    endfunction

    function automatic logic [xlen-1:0] b_type(logic [2:0] f3, reg_addr_t rs1, reg_addr_t rs2,
                                               logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
    endfunction

    function automatic logic [xlen-1:0] lui_instr(reg_addr_t rd, logic [19:0] imm);
        return {imm, rd, op_lui};
    endfunction

    function automatic logic [xlen-1:0] jal_instr(reg_addr_t rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
    endfunction

    task automatic stop_on_failure();
        $display("** FAIL **");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_value(string name, logic [xlen-1:0] actual, logic [xlen-1:0] expected);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            stop_on_failure();
        end
    endtask

    task automatic emit(logic [xlen-1:0] instr);
        prog.push_back(instr);
    endtask

    // LUI takes the rounded upper part so the signed ADDI lands on value
    task automatic load_const(reg_addr_t rd, logic [xlen-1:0] value);
        logic [xlen-1:0] upper;
        upper = value + 32'h800;
        emit(lui_instr(rd, upper[31:12]));
        emit(i_type(value[11:0], rd, 3'b000, rd));
    endtask

    task automatic store_and_expect(reg_addr_t src, logic [11:0] addr, logic [xlen-1:0] value);
        emit(sw_instr(src, 5'd0, addr));
        exp_addr.push_back({20'b0, addr});
        exp_data.push_back(value);
    endtask

    task automatic clear_program();
        prog.delete();
        exp_addr.delete();
        exp_data.delete();
    endtask

    task automatic reset_dut();
        rst = 1'b1;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        seen_addr.delete();
        seen_data.delete();
    endtask

    task automatic start_program();
        rst = 1'b1;
        // Unused words hold JAL x0, 0 so the core parks in a loop
        for (int i = 0; i < 256; i++) begin
            if (i < prog.size()) begin
                imem[i] = prog[i];
            end else begin
                imem[i] = jal_instr(5'd0, 21'd0);
            end
        end
        reset_dut();
    endtask

    task automatic expect_write(logic [xlen-1:0] addr, logic [xlen-1:0] data);
        int cycles;
        cycles = 0;
        while (seen_addr.size() == 0 && cycles < 200) begin
            @(negedge clk);
            cycles++;
        end
        if (seen_addr.size() == 0) begin
            $display("Timeout at %0t ns: no data-port write to %h within 200 cycles", $time, addr);
            stop_on_failure();
        end
        check_value("dm_addr", seen_addr.pop_front(), addr);
        check_value("dm_wdata", seen_data.pop_front(), data);
    endtask

    task automatic await_writes(int count);
        for (int i = 0; i < count; i++) begin
            expect_write(exp_addr[i], exp_data[i]);
        end
    endtask

    task automatic expect_quiet();
        repeat (24) @(negedge clk);
        if (seen_addr.size() != 0) begin
            $display("Unexpected data-port write to %h after the last store", seen_addr[0]);
            stop_on_failure();
        end
    endtask

    task automatic alu_and_immediates();
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [11:0]     imm;
        logic [xlen-1:0] imm_x;
        clear_program();
        a = $random(seed);
        b = $random(seed);
        imm = 12'($random(seed));
        imm_x = {{20{imm[11]}}, imm};
        load_const(5'd1, a);
        load_const(5'd2, b);
        store_and_expect(5'd1, 12'h100, a);
        emit(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
        store_and_expect(5'd3, 12'h104, a + b);
        emit(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd4));
        store_and_expect(5'd4, 12'h108, a - b);
        emit(r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd5));
        store_and_expect(5'd5, 12'h10c, a & b);
        emit(r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd6));
        store_and_expect(5'd6, 12'h110, a | b);
        emit(r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd7));
        store_and_expect(5'd7, 12'h114, a ^ b);
        emit(r_type(7'h00, 5'd2, 5'd1, 3'b010, 5'd8));
        store_and_expect(5'd8, 12'h118, {31'b0, $signed(a) < $signed(b)});
        emit(r_type(7'h00, 5'd2, 5'd1, 3'b001, 5'd9));
        store_and_expect(5'd9, 12'h11c, a << b[4:0]);
        emit(r_type(7'h00, 5'd2, 5'd1, 3'b101, 5'd10));
        store_and_expect(5'd10, 12'h120, a >> b[4:0]);
        emit(r_type(7'h20, 5'd2, 5'd1, 3'b101, 5'd11));
        store_and_expect(5'd11, 12'h124, $signed(a) >>> b[4:0]);
        emit(i_type(imm, 5'd1, 3'b000, 5'd12));
        store_and_expect(5'd12, 12'h128, a + imm_x);
        emit(i_type(imm, 5'd1, 3'b111, 5'd13));
        store_and_expect(5'd13, 12'h12c, a & imm_x);
        emit(i_type(imm, 5'd1, 3'b110, 5'd14));
        store_and_expect(5'd14, 12'h130, a | imm_x);
        emit(i_type(imm, 5'd1, 3'b100, 5'd15));
        store_and_expect(5'd15, 12'h134, a ^ imm_x);
        emit(i_type(imm, 5'd1, 3'b010, 5'd16));
        store_and_expect(5'd16, 12'h138, {31'b0, $signed(a) < $signed(imm_x)});
        start_program();
        await_writes(exp_addr.size());
        expect_quiet();
    endtask

    task automatic forwarding_chains();
        logic [xlen-1:0] vals [1:10];
        clear_program();
        vals[1] = $random(seed);
        vals[2] = $random(seed);
        load_const(5'd1, vals[1]);
        load_const(5'd2, vals[2]);
        // Each result feeds the next two instructions directly
        for (int r = 3; r <= 10; r++) begin
            if (r % 2 == 1) begin
                emit(r_type(7'h00, 5'(r - 2), 5'(r - 1), 3'b000, 5'(r)));
                vals[r] = vals[r - 1] + vals[r - 2];
            end else begin
                emit(r_type(7'h20, 5'(r - 2), 5'(r - 1), 3'b000, 5'(r)));
                vals[r] = vals[r - 1] - vals[r - 2];
            end
        end
        for (int r = 10; r >= 3; r--) begin
            store_and_expect(5'(r), 12'(32'h140 + 4 * (10 - r)), vals[r]);
        end
        start_program();
        await_writes(exp_addr.size());
        expect_quiet();
    endtask

    task automatic load_use();
        logic [xlen-1:0] a;
        logic [xlen-1:0] addend;
        clear_program();
        a = $random(seed);
        addend = $random(seed);
        load_const(5'd1, a);
        load_const(5'd4, addend);
        store_and_expect(5'd1, 12'h180, a);
        emit(lw_instr(5'd2, 5'd0, 12'h180));
        emit(r_type(7'h00, 5'd4, 5'd2, 3'b000, 5'd3));
        store_and_expect(5'd3, 12'h184, a + addend);
        // Word 8 is never stored, so it still holds its fill value
        emit(lw_instr(5'd5, 5'd0, 12'h020));
        store_and_expect(5'd5, 12'h188, dmem[8]);
        emit(lw_instr(5'd6, 5'd0, 12'h184));
        emit(r_type(7'h20, 5'd6, 5'd4, 3'b000, 5'd7));
        store_and_expect(5'd7, 12'h18c, addend - (a + addend));
        start_program();
        await_writes(exp_addr.size());
        expect_quiet();
    endtask

    task automatic branches_and_jump();
        logic [xlen-1:0] marks [10:15];
        logic [xlen-1:0] jal_pc;
        clear_program();
        for (int k = 10; k <= 15; k++) begin
            marks[k] = $random(seed);
            load_const(5'(k), marks[k]);
        end
        emit(i_type(12'd5, 5'd0, 3'b000, 5'd1));
        emit(i_type(12'd5, 5'd0, 3'b000, 5'd2));
        emit(i_type(12'd7, 5'd0, 3'b000, 5'd3));
        // Taken BEQ
        emit(b_type(3'b000, 5'd1, 5'd2, 13'd12));
        emit(sw_instr(5'd10, 5'd0, 12'h1e0));
        emit(sw_instr(5'd11, 5'd0, 12'h1e4));
        store_and_expect(5'd12, 12'h1c0, marks[12]);
        emit(b_type(3'b001, 5'd1, 5'd2, 13'd12));
        store_and_expect(5'd13, 12'h1c4, marks[13]);
        emit(b_type(3'b000, 5'd1, 5'd3, 13'd12));
        store_and_expect(5'd14, 12'h1c8, marks[14]);
        // Taken BNE
        emit(b_type(3'b001, 5'd1, 5'd3, 13'd12));
        emit(sw_instr(5'd10, 5'd0, 12'h1e8));
        emit(sw_instr(5'd11, 5'd0, 12'h1ec));
        jal_pc = 32'(prog.size() * 4);
        emit(jal_instr(5'd5, 21'd12));
        emit(sw_instr(5'd10, 5'd0, 12'h1f0));
        emit(sw_instr(5'd11, 5'd0, 12'h1f4));
        store_and_expect(5'd5, 12'h1cc, jal_pc + 32'd4);
        store_and_expect(5'd15, 12'h1d0, marks[15]);
        start_program();
        await_writes(exp_addr.size());
        expect_quiet();
    endtask

    task automatic x0_and_reset();
        logic [xlen-1:0] v;
        clear_program();
        v = $random(seed);
        emit(i_type(12'h123, 5'd0, 3'b000, 5'd0));
        emit(lui_instr(5'd0, 20'habcde));
        load_const(5'd1, v);
        emit(r_type(7'h00, 5'd1, 5'd1, 3'b000, 5'd0));
        store_and_expect(5'd0, 12'h200, 32'd0);
        emit(r_type(7'h00, 5'd0, 5'd1, 3'b000, 5'd6));
        store_and_expect(5'd6, 12'h204, v);
        for (int k = 0; k < 6; k++) begin
            emit(i_type(12'(k + 1), 5'd6, 3'b000, 5'd6));
            v = v + 32'(k + 1);
            store_and_expect(5'd6, 12'(32'h208 + 4 * k), v);
        end
        start_program();
        await_writes(2);
        // Restart from address 0 while the program is still running
        reset_dut();
        await_writes(exp_addr.size());
        expect_quiet();
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        seed = 77365;
        for (int i = 0; i < 256; i++) begin
            imem[i] = jal_instr(5'd0, 21'd0);
            dmem[i] = fill_word(i);
        end
        alu_and_immediates();
        forwarding_chains();
        load_use();
        branches_and_jump();
        x0_and_reset();
        $display("** PASS **");
        $finish;
    end

endmodule

//--- cpu.f
source/cpu_pkg.sv
source/result_if.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_writeback.sv
source/cpu.sv
sim/cpu_properties.sv
sim/tb_cpu.sv

//--- Makefile
TOP = tb_cpu

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps --top-module $(TOP) -f cpu.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qF '** PASS **'

clean:
	rm -rf obj_dir

.PHONY: sim clean
